// File: logic/scaler_pkg.sv
package scaler_pkg;

    typedef logic [7:0]  pixel_t;
    typedef logic [10:0] coord_t;
    typedef logic [26:0] pos_t;     // 11 integer bits, 16 fraction bits
    typedef logic [16:0] weight_t;  // one is 17'h10000

    typedef struct packed {
        logic vsync;
        logic href;
    } sync_t;

    // ------------------------------
    // line buffer ports

    typedef struct packed {
        logic       we0;    // even source rows
        logic       we1;    // odd source rows
        logic [1:0] slot;
        coord_t     col;
        pixel_t     data;
    } buf_wr_t;

    // second port of each bank reads col + 1
    typedef struct packed {
        logic [1:0] slot0;
        coord_t     col0;
        logic [1:0] slot1;
        coord_t     col1;
    } buf_rd_t;

    typedef struct packed {
        pixel_t p00;
        pixel_t p01;
        pixel_t p10;
        pixel_t p11;
    } quad_t;

    typedef struct packed {
        coord_t      x;
        coord_t      y;
        logic [15:0] fx;
        logic [15:0] fy;
    } pix_req_t;

endpackage

// File: logic/line_writer.sv
module line_writer #(
    parameter int SRC_W = 800
) (
    input  logic                clk_in2,
    input  logic                rst_n,
    input  scaler_pkg::sync_t   in_sync,
    input  scaler_pkg::pixel_t  in_gray,
    output scaler_pkg::buf_wr_t buf_wr,
    output logic                line_done,
    output logic                frame_start
);

    scaler_pkg::sync_t  sync_d;
    scaler_pkg::coord_t col_cnt;
    scaler_pkg::coord_t row_cnt;
    scaler_pkg::coord_t col_q;
    scaler_pkg::pixel_t data_q;
    logic [1:0]         slot_q;
    logic               we0_q;
    logic               we1_q;
    logic               active;
    logic               href_fall;

    assign active    = in_sync.vsync & in_sync.href;
    assign href_fall = sync_d.href & ~in_sync.href;

    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
        begin
            sync_d      <= '0;
            col_cnt     <= '0;
            row_cnt     <= '0;
            we0_q       <= 1'b0;
            we1_q       <= 1'b0;
            line_done   <= 1'b0;
            frame_start <= 1'b0;
        end
        else
        begin
            sync_d  <= in_sync;
            col_cnt <= active ? col_cnt + 1'b1 : '0;
            if (!in_sync.vsync)
                row_cnt <= '0;
            else if (href_fall)
                row_cnt <= row_cnt + 1'b1;
            we0_q       <= active & ~row_cnt[0];  // bank by row parity
            we1_q       <= active & row_cnt[0];
            line_done   <= active && (col_cnt == scaler_pkg::coord_t'(SRC_W - 1));
            frame_start <= in_sync.vsync & ~sync_d.vsync;
        end
    end

    always_ff @(posedge clk_in2)
    begin
        slot_q <= row_cnt[2:1];
        col_q  <= col_cnt;
        data_q <= in_gray;
    end

    assign buf_wr = '{we0: we0_q, we1: we1_q, slot: slot_q, col: col_q, data: data_q};

endmodule

// File: logic/line_buffer.sv
module line_buffer #(
    parameter int SRC_W = 800
) (
    input  logic                clk_in2,
    input  scaler_pkg::buf_wr_t buf_wr,
    input  scaler_pkg::buf_rd_t buf_rd,
    output scaler_pkg::quad_t   raw
);

    localparam int DEPTH = 4 * SRC_W;
    localparam int AW    = $clog2(DEPTH);

    // copies: bank0 col, bank0 col+1, bank1 col, bank1 col+1
    scaler_pkg::pixel_t  mem [4][DEPTH];
    scaler_pkg::buf_rd_t rd_q;
    logic [AW-1:0]       wr_addr;
    logic [AW-1:0]       rd_addr [4];

    function automatic logic [AW-1:0] row_addr(input logic [1:0] slot,
                                               input scaler_pkg::coord_t col);
        return AW'(slot) * AW'(SRC_W) + AW'(col);
    endfunction

    always_comb
    begin
        wr_addr    = row_addr(buf_wr.slot, buf_wr.col);
        rd_addr[0] = row_addr(rd_q.slot0, rd_q.col0);
        rd_addr[1] = row_addr(rd_q.slot0, rd_q.col0 + 1'b1);  // past the row end at the right edge
        rd_addr[2] = row_addr(rd_q.slot1, rd_q.col1);
        rd_addr[3] = row_addr(rd_q.slot1, rd_q.col1 + 1'b1);
    end

    always_ff @(posedge clk_in2)
    begin
        rd_q <= buf_rd;
        if (buf_wr.we0)
        begin
            mem[0][wr_addr] <= buf_wr.data;
            mem[1][wr_addr] <= buf_wr.data;
        end
        if (buf_wr.we1)
        begin
            mem[2][wr_addr] <= buf_wr.data;
            mem[3][wr_addr] <= buf_wr.data;
        end
        raw <= '{p00: mem[0][rd_addr[0]], p01: mem[1][rd_addr[1]],
                 p10: mem[2][rd_addr[2]], p11: mem[3][rd_addr[3]]};
    end

endmodule

// File: logic/scale_sequencer.sv
module scale_sequencer #(
    parameter int SRC_H   = 600,
    parameter int DST_W   = 1280,
    parameter int DST_H   = 720,
    parameter int X_RATIO = 40960,
    parameter int Y_RATIO = 54613
) (
    input  logic                 clk_in2,
    input  logic                 rst_n,
    input  logic                 line_done,
    input  logic                 frame_start,
    output logic                 pix_valid,
    output scaler_pkg::pix_req_t pix_req,
    output scaler_pkg::sync_t    seq_sync
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ROW_CHECK,
        S_ROW_EMIT,
        S_ROW_INC
    } state_t;

    state_t             state;
    scaler_pkg::coord_t rows_written;
    scaler_pkg::coord_t dst_row;
    scaler_pkg::coord_t dst_col;
    scaler_pkg::pos_t   x_acc;
    scaler_pkg::pos_t   y_acc;
    logic               vsync_q;
    logic               row_ready;
    logic               last_col;
    logic               last_row;

    // rows y and y + 1 both in the buffer
    assign row_ready = ({1'b0, rows_written} > {1'b0, y_acc[26:16]} + 12'd1) ||
                       (rows_written == scaler_pkg::coord_t'(SRC_H));
    assign last_col  = dst_col == scaler_pkg::coord_t'(DST_W - 1);
    assign last_row  = dst_row == scaler_pkg::coord_t'(DST_H - 1);

    // ------------------------------
    // row state machine
    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
        begin
            state        <= S_IDLE;
            rows_written <= '0;
            dst_row      <= '0;
            dst_col      <= '0;
            x_acc        <= '0;
            y_acc        <= '0;
            pix_valid    <= 1'b0;
            vsync_q      <= 1'b0;
        end
        else
        begin
            case (state)
                S_IDLE:      if (frame_start) state <= S_ROW_CHECK;
                S_ROW_CHECK: if (row_ready) state <= S_ROW_EMIT;
                S_ROW_EMIT:  if (last_col) state <= S_ROW_INC;
                S_ROW_INC:   state <= last_row ? S_IDLE : S_ROW_CHECK;
                default:     state <= S_IDLE;
            endcase

            if (frame_start)
                rows_written <= '0;
            else if (line_done)
                rows_written <= rows_written + 1'b1;

            if (frame_start)
            begin
                y_acc   <= '0;
                dst_row <= '0;
            end
            else if (state == S_ROW_INC)
            begin
                y_acc   <= y_acc + scaler_pkg::pos_t'(Y_RATIO);
                dst_row <= dst_row + 1'b1;
            end

            if (state == S_ROW_EMIT)
            begin
                x_acc   <= x_acc + scaler_pkg::pos_t'(X_RATIO);
                dst_col <= dst_col + 1'b1;
            end
            else
            begin
                x_acc   <= '0;   // new row starts at x = 0
                dst_col <= '0;
            end

            pix_valid <= state == S_ROW_EMIT;
            if ((state == S_ROW_EMIT) && (dst_col == '0) && (dst_row == '0))
                vsync_q <= 1'b1;
            else if ((state == S_ROW_INC) && last_row)
                vsync_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_in2)
    begin
        pix_req <= '{x: x_acc[26:16], y: y_acc[26:16], fx: x_acc[15:0], fy: y_acc[15:0]};
    end

    assign seq_sync = '{vsync: vsync_q, href: pix_valid};

endmodule

// File: logic/interp_datapath.sv
module interp_datapath #(
    parameter int SRC_W = 800,
    parameter int SRC_H = 600
) (
    input  logic                 clk_in2,
    input  logic                 rst_n,
    input  logic                 pix_valid,
    input  scaler_pkg::pix_req_t pix_req,
    input  scaler_pkg::sync_t    seq_sync,
    output scaler_pkg::buf_rd_t  buf_rd,
    input  scaler_pkg::quad_t    raw,
    output scaler_pkg::sync_t    out_sync,
    output scaler_pkg::pixel_t   out_gray
);

    localparam int LAT = 11;

    typedef struct packed {
        logic odd;      // row y sits in bank 1
        logic right;
        logic bottom;
    } edge_t;

    scaler_pkg::sync_t   sync_d [1:LAT];
    edge_t               edge_d [1:5];
    scaler_pkg::coord_t  x_c1;
    scaler_pkg::coord_t  y_c1;
    scaler_pkg::coord_t  y_next;
    scaler_pkg::weight_t fx_c1;
    scaler_pkg::weight_t fy_c1;
    scaler_pkg::weight_t ifx_c1;
    scaler_pkg::weight_t ify_c1;
    logic [3:0][33:0]    wt_d [2:6];   // [0] w00 .. [3] w11
    scaler_pkg::quad_t   q_c5;
    scaler_pkg::quad_t   q_c6;
    logic [41:0]         prod_c7 [4];
    logic [42:0]         pair_c8 [2];
    logic [43:0]         sum_c9;
    logic [11:0]         rnd_c10;

    function automatic logic [33:0] wmul(input scaler_pkg::weight_t a,
                                         input scaler_pkg::weight_t b);
        return a * b;
    endfunction

    assign y_next = y_c1 + 1'b1;

    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
        begin
            for (int i = 1; i <= LAT; i++)
                sync_d[i] <= '0;
        end
        else
        begin
            sync_d[1] <= seq_sync;
            for (int i = 2; i <= LAT; i++)
                sync_d[i] <= sync_d[i-1];
        end
    end

    assign out_sync = sync_d[LAT];

    // ------------------------------
    // request, address, weights
    always_ff @(posedge clk_in2)
    begin
        if (pix_valid)
        begin
            x_c1      <= pix_req.x;
            y_c1      <= pix_req.y;
            fx_c1     <= {1'b0, pix_req.fx};
            fy_c1     <= {1'b0, pix_req.fy};
            ifx_c1    <= 17'h10000 - {1'b0, pix_req.fx};
            ify_c1    <= 17'h10000 - {1'b0, pix_req.fy};
            edge_d[1] <= '{odd: pix_req.y[0],
                           right: pix_req.x == scaler_pkg::coord_t'(SRC_W - 1),
                           bottom: pix_req.y == scaler_pkg::coord_t'(SRC_H - 1)};
        end
        for (int i = 2; i <= 5; i++)
            edge_d[i] <= edge_d[i-1];

        // bank 0 slot follows y + 1 and bank 1 slot follows y
        buf_rd  <= '{slot0: y_next[2:1], col0: x_c1,
                     slot1: y_c1[2:1], col1: x_c1};
        wt_d[2] <= {wmul(fx_c1, fy_c1), wmul(ifx_c1, fy_c1),
                    wmul(fx_c1, ify_c1), wmul(ifx_c1, ify_c1)};
        for (int i = 3; i <= 6; i++)
            wt_d[i] <= wt_d[i-1];
    end

    // ------------------------------
    // pixels, edges, weighted sum
    always_ff @(posedge clk_in2)
    begin
        if (edge_d[4].odd)
            q_c5 <= '{p00: raw.p10, p01: raw.p11, p10: raw.p00, p11: raw.p01};
        else
            q_c5 <= raw;

        q_c6 <= q_c5;
        if (edge_d[5].right)
        begin
            q_c6.p01 <= q_c5.p00;
            q_c6.p11 <= edge_d[5].bottom ? q_c5.p00 : q_c5.p10;
        end
        else if (edge_d[5].bottom)
            q_c6.p11 <= q_c5.p01;
        if (edge_d[5].bottom)
            q_c6.p10 <= q_c5.p00;

        prod_c7[0] <= wt_d[6][0] * q_c6.p00;
        prod_c7[1] <= wt_d[6][1] * q_c6.p01;
        prod_c7[2] <= wt_d[6][2] * q_c6.p10;
        prod_c7[3] <= wt_d[6][3] * q_c6.p11;
        pair_c8[0] <= prod_c7[0] + prod_c7[1];
        pair_c8[1] <= prod_c7[2] + prod_c7[3];
        sum_c9     <= pair_c8[0] + pair_c8[1];
        rnd_c10    <= sum_c9[43:32] + 12'(sum_c9[31]);  // round half up
        out_gray   <= (rnd_c10 > 12'd255) ? 8'd255 : rnd_c10[7:0];
    end

endmodule

// File: logic/img_scaler_top.sv
module img_scaler_top #(
    parameter int SRC_W   = 800,
    parameter int SRC_H   = 600,
    parameter int DST_W   = 1280,
    parameter int DST_H   = 720,
    parameter int X_RATIO = (SRC_W * 65536) / DST_W,
    parameter int Y_RATIO = (SRC_H * 65536) / DST_H
) (
    input  logic               clk_in2,
    input  logic               rst_n,
    input  scaler_pkg::sync_t  in_sync,
    input  scaler_pkg::pixel_t in_gray,
    output scaler_pkg::sync_t  out_sync,
    output scaler_pkg::pixel_t out_gray
);

    scaler_pkg::buf_wr_t  buf_wr;
    scaler_pkg::buf_rd_t  buf_rd;
    scaler_pkg::quad_t    raw;
    scaler_pkg::pix_req_t pix_req;
    scaler_pkg::sync_t    seq_sync;
    logic                 line_done;
    logic                 frame_start;
    logic                 pix_valid;

    line_writer #(.SRC_W(SRC_W)) writer_i (.clk_in2(clk_in2), .rst_n(rst_n),
        .in_sync(in_sync), .in_gray(in_gray), .buf_wr(buf_wr),
        .line_done(line_done), .frame_start(frame_start));

    line_buffer #(.SRC_W(SRC_W)) buffer_i (.clk_in2(clk_in2), .buf_wr(buf_wr),
        .buf_rd(buf_rd), .raw(raw));

    scale_sequencer #(.SRC_H(SRC_H), .DST_W(DST_W), .DST_H(DST_H),
        .X_RATIO(X_RATIO), .Y_RATIO(Y_RATIO)) seq_i (.clk_in2(clk_in2),
        .rst_n(rst_n), .line_done(line_done), .frame_start(frame_start),
        .pix_valid(pix_valid), .pix_req(pix_req), .seq_sync(seq_sync));

    interp_datapath #(.SRC_W(SRC_W), .SRC_H(SRC_H)) interp_i (.clk_in2(clk_in2),
        .rst_n(rst_n), .pix_valid(pix_valid), .pix_req(pix_req),
        .seq_sync(seq_sync), .buf_rd(buf_rd), .raw(raw),
        .out_sync(out_sync), .out_gray(out_gray));

endmodule

// File: verif/img_scaler_sva.sv
module img_scaler_sva #(
    parameter int DST_W = 1280
) (
    input logic              clk_in2,
    input logic              rst_n,
    input scaler_pkg::sync_t out_sync
);
    timeunit 1ns;
    timeprecision 1ps;

    int run_cnt;    // href-high samples in the current run

    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
            run_cnt <= 0;
        else if (out_sync.href)
            run_cnt <= run_cnt + 1;
        else
            run_cnt <= 0;
    end

    href_in_frame: assert property (@(posedge clk_in2) disable iff (!rst_n)
        $rose(out_sync.href) |-> out_sync.vsync)
        else $error("href rose while vsync was low");

    // a run neither grows past DST_W nor ends short of it
    run_not_long: assert property (@(posedge clk_in2) disable iff (!rst_n)
        out_sync.href |-> run_cnt < DST_W)
        else $error("href run longer than one output row");

    run_not_short: assert property (@(posedge clk_in2) disable iff (!rst_n)
        $fell(out_sync.href) |-> run_cnt == DST_W)
        else $error("href run of %0d cycles ended short", run_cnt);

endmodule

bind img_scaler_top img_scaler_sva #(.DST_W(DST_W)) sva_i (
    .clk_in2(clk_in2), .rst_n(rst_n), .out_sync(out_sync));

// File: verif/tb_img_scaler.sv
module tb_img_scaler;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SRC_W    = 16;
    localparam int SRC_H    = 12;
    localparam int DST_W    = 24;
    localparam int DST_H    = 18;
    localparam int X_RATIO  = (SRC_W * 65536) / DST_W;
    localparam int Y_RATIO  = (SRC_H * 65536) / DST_H;
    localparam int GAP      = 3 * (DST_W + 4);
    localparam int LINE_PER = SRC_W + GAP;
    localparam int N_FRAMES = 3;
    localparam int TIMEOUT  = N_FRAMES * (SRC_H * LINE_PER + DST_W * 4) + 2000;

    logic               clk_in2 = 1'b0;
    logic               rst_n;
    scaler_pkg::sync_t  in_sync;
    scaler_pkg::pixel_t in_gray;
    scaler_pkg::sync_t  out_sync;
    scaler_pkg::pixel_t out_gray;

    logic [7:0]        src [SRC_H][SRC_W];
    logic [7:0]        exp_q [$];
    logic [7:0]        exp_pix;
    scaler_pkg::sync_t prev_sync = '0;
    logic              input_started = 1'b0;
    int                run_len = 0;
    int                out_row = 0;
    int                frames_seen = 0;
    int                cycles = 0;
    int                value_errs = 0;
    int                frame_errs = 0;
    int                other_errs = 0;

    img_scaler_top #(
        .SRC_W(SRC_W), .SRC_H(SRC_H), .DST_W(DST_W), .DST_H(DST_H),
        .X_RATIO(X_RATIO), .Y_RATIO(Y_RATIO)
    ) dut_i (
        .clk_in2(clk_in2), .rst_n(rst_n), .in_sync(in_sync), .in_gray(in_gray),
        .out_sync(out_sync), .out_gray(out_gray)
    );

    always #10 clk_in2 = ~clk_in2;

    // ------------------------------
    // bilinear reference
    function automatic logic [7:0] model_pixel(input int i, input int j);
        longint unsigned xp;
        longint unsigned yp;
        longint unsigned fx;
        longint unsigned fy;
        longint unsigned sum;
        int              x0;
        int              y0;
        int              x1;
        int              y1;
        xp  = longint'(j) * X_RATIO;
        yp  = longint'(i) * Y_RATIO;
        fx  = xp & 64'hffff;
        fy  = yp & 64'hffff;
        x0  = int'(xp >> 16);
        y0  = int'(yp >> 16);
        x1  = (x0 + 1 < SRC_W) ? x0 + 1 : SRC_W - 1;   // clamp at the right edge
        y1  = (y0 + 1 < SRC_H) ? y0 + 1 : SRC_H - 1;
        sum = (65536 - fx) * (65536 - fy) * src[y0][x0]
            + fx * (65536 - fy) * src[y0][x1]
            + (65536 - fx) * fy * src[y1][x0]
            + fx * fy * src[y1][x1];
        sum = (sum + 64'h8000_0000) >> 32;
        return (sum > 255) ? 8'hff : 8'(sum);
    endfunction

    // kind 0 bright border, 1 all white, 2 random extremes
    task automatic fill_frame(input int kind);
        logic [7:0] ext [4];
        int         r;
        int         c;
        ext = '{8'h00, 8'h01, 8'hfe, 8'hff};
        for (r = 0; r < SRC_H; r++)
            for (c = 0; c < SRC_W; c++)
                case (kind)
                    0:       src[r][c] = (r == SRC_H - 1 || c == SRC_W - 1) ? 8'hff
                                                                            : 8'($urandom % 128);
                    1:       src[r][c] = 8'hff;
                    default: src[r][c] = ext[$urandom % 4];
                endcase
        for (r = 0; r < DST_H; r++)
            for (c = 0; c < DST_W; c++)
                exp_q.push_back(model_pixel(r, c));
    endtask

    task automatic send_frame();
        int r;
        int c;
        repeat (5 + $urandom % 16) @(negedge clk_in2);
        in_sync.vsync = 1'b1;
        input_started = 1'b1;
        repeat (2) @(negedge clk_in2);
        for (r = 0; r < SRC_H; r++)
        begin
            for (c = 0; c < SRC_W; c++)
            begin
                in_sync.href = 1'b1;
                in_gray      = src[r][c];
                @(negedge clk_in2);
            end
            in_sync.href = 1'b0;
            in_gray      = '0;
            repeat (GAP) @(negedge clk_in2);    // line gap keeps the buffer from wrapping
        end
        in_sync.vsync = 1'b0;
    endtask

    // ------------------------------
    // output monitor, sampled mid-cycle
    always @(negedge clk_in2)
    begin
        if (!input_started)
            assert (out_sync == '0)
            else
            begin
                value_errs++;
                $display("ERR out_sync: expected %h, got %h", 2'b00, out_sync);
            end
        if (out_sync.href)
        begin
            assert (out_sync.vsync)
            else
            begin
                frame_errs++;
                $display("href high while vsync is low, output row %0d", out_row);
            end
            if (exp_q.size() == 0)
            begin
                other_errs++;
                $display("output pixel arrived with no expected value left");
            end
            else
            begin
                exp_pix = exp_q.pop_front();
                assert (out_gray === exp_pix)
                else
                begin
                    value_errs++;
                    $display("ERR out_gray frame %0d row %0d col %0d: expected %h, got %h",
                             frames_seen, out_row, run_len, exp_pix, out_gray);
                end
            end
            if (frames_seen == 1)   // the all-white frame
                assert (out_gray == 8'hff)
                else
                begin
                    value_errs++;
                    $display("ERR out_gray white frame: expected %h, got %h", 8'hff, out_gray);
                end
            run_len++;
        end
        else if (prev_sync.href)
        begin
            assert (run_len == DST_W)
            else
            begin
                frame_errs++;
                $display("output row %0d had %0d pixels instead of %0d", out_row, run_len, DST_W);
            end
            out_row++;
            run_len = 0;
        end
        if (prev_sync.vsync && !out_sync.vsync)
        begin
            assert (out_row == DST_H)
            else
            begin
                frame_errs++;
                $display("frame %0d ended after %0d rows instead of %0d",
                         frames_seen, out_row, DST_H);
            end
            frames_seen++;
            out_row = 0;
        end
        prev_sync = out_sync;
    end

    always @(posedge clk_in2)
    begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT)
        begin
            $display("timeout after %0d cycles with %0d of %0d frames seen",
                     cycles, frames_seen, N_FRAMES);
            $display("errors: %0d value, %0d framing, %0d other",
                     value_errs, frame_errs, other_errs + 1);
            $display("Test failed");
            $finish;
        end
    end

    initial
    begin
        int k;
        void'($urandom(32'h4971f0ca));
        rst_n   = 1'b0;
        in_sync = '0;
        in_gray = '0;
        repeat (4) @(negedge clk_in2);
        rst_n = 1'b1;
        repeat (20) @(negedge clk_in2);   // quiet outputs before any input
        for (k = 0; k < N_FRAMES; k++)
        begin
            fill_frame(k);
            send_frame();
        end
        while (frames_seen < N_FRAMES)
            @(negedge clk_in2);
        repeat (5) @(negedge clk_in2);
        assert (exp_q.size() == 0)
        else
        begin
            other_errs++;
            $display("%0d expected pixels never appeared at the output", exp_q.size());
        end
        $display("errors: %0d value, %0d framing, %0d other", value_errs, frame_errs, other_errs);
        if (value_errs + frame_errs + other_errs == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: flist.f
logic/scaler_pkg.sv
logic/line_writer.sv
logic/line_buffer.sv
logic/scale_sequencer.sv
logic/interp_datapath.sv
logic/img_scaler_top.sv
verif/img_scaler_sva.sv
verif/tb_img_scaler.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the scaler testbench with Verilator, run it, scan the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_img_scaler -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_img_scaler +verilator+error+limit+1000 > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Test failed" "$log"; then
    exit 1
fi
exit 0
